//--- project.f
+incdir+source
source/mem_pkg.sv
source/reg_access_if.sv
source/axil_slave.sv
source/ctrl_regs.sv
source/burst_read_master.sv
source/burst_write_master.sv
source/mem_subsystem_top.sv
dv/mem_subsystem_properties.sv
dv/mem_subsystem_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f \
   --top-module mem_subsystem_tb -o mem_subsystem_sim

./obj_dir/mem_subsystem_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation passed$" sim.log; then
   exit 0
fi
exit 1

//--- dv/mem_subsystem_tb.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_subsystem_tb import mem_pkg::*; ;

   localparam int TIMEOUT_CYCLES = 4000;

   logic clk, rst_n_i;
   reg_addr_t s_axi_awaddr_i, s_axi_araddr_i;
   logic s_axi_awvalid_i, s_axi_awready_o, s_axi_wvalid_i, s_axi_wready_o;
   logic s_axi_bvalid_o, s_axi_bready_i, s_axi_arvalid_i, s_axi_arready_o;
   logic s_axi_rvalid_o, s_axi_rready_i;
   word_t s_axi_wdata_i, s_axi_rdata_o;
   strb_t s_axi_wstrb_i, m_axi_wstrb_o;
   logic ce_o, fin_interrupt_i, interrupt_o;
   addr_t pc_i, read_address_i, write_address_i, m_axi_awaddr_o, m_axi_araddr_o;
   logic read_init_i, read_next_o, write_init_i, write_next_o, write_done_o;
   word_t read_data_o, write_data_i, m_axi_wdata_o, m_axi_rdata_i;
   logic m_axi_awvalid_o, m_axi_awready_i, m_axi_wlast_o, m_axi_wvalid_o, m_axi_wready_i;
   logic m_axi_bvalid_i, m_axi_bready_o, m_axi_arvalid_o, m_axi_arready_i;
   logic m_axi_rlast_i, m_axi_rvalid_i, m_axi_rready_o;

   word_t mem [256];                  // DDR model, word indexed
   word_t rd_words [16];
   word_t wb_words [16];
   int rd_got, wb_idx, done_cnt, errors, cycles;
   addr_t ar_seen, aw_seen;
   logic stall_en;
   logic [31:0] rng_model, rng_data;
   int rd_cnt, wr_cnt;
   logic rd_busy, wr_busy, resp_pending;
   logic [7:0] rd_ptr, wr_ptr;
   string cur_test;                   // Burst test in progress

   mem_subsystem_top dut0 (.*);

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   // Every address bit shows up in the word
   function automatic word_t fill_word(input logic [7:0] i);
      return {8'hA5, i, ~i, i ^ 8'h3C};
   endfunction

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Simulation failed");
         $finish;
      end
   end

   // DDR slave with optional random stalls
   always @(posedge clk) begin
      rng_model = xorshift(rng_model);
      if (m_axi_arvalid_o && m_axi_arready_i) begin
         rd_busy = 1'b1;
         rd_ptr  = m_axi_araddr_o[9:2];
         rd_cnt  = 0;
         ar_seen <= m_axi_araddr_o;
         m_axi_arready_i <= 1'b0;
      end else
         m_axi_arready_i <= m_axi_arvalid_o & ~rd_busy & (~stall_en | rng_model[0]);
      if (m_axi_rvalid_i && m_axi_rready_o) begin
         rd_cnt++;
         if (rd_cnt == `MEM_BURST_LEN)
            rd_busy = 1'b0;
      end
      if (rd_busy && (!m_axi_rvalid_i || m_axi_rready_o)) begin
         m_axi_rvalid_i <= ~stall_en | rng_model[1];
         m_axi_rdata_i  <= mem[rd_ptr + rd_cnt[7:0]];
         m_axi_rlast_i  <= (rd_cnt == `MEM_BURST_LEN - 1);
      end else if (!rd_busy) begin
         m_axi_rvalid_i <= 1'b0;
         m_axi_rlast_i  <= 1'b0;
      end
      if (m_axi_awvalid_o && m_axi_awready_i) begin
         wr_busy = 1'b1;
         wr_ptr  = m_axi_awaddr_o[9:2];
         wr_cnt  = 0;
         aw_seen <= m_axi_awaddr_o;
         m_axi_awready_i <= 1'b0;
      end else
         m_axi_awready_i <= m_axi_awvalid_o & ~wr_busy & (~stall_en | rng_model[2]);
      if (m_axi_wvalid_o && m_axi_wready_i) begin
         check_bit({cur_test, " wlast"}, wr_cnt == `MEM_BURST_LEN - 1, m_axi_wlast_o);
         check_word({cur_test, " wstrb"}, word_t'({(`MEM_DATA_W/8){1'b1}}),
                    word_t'(m_axi_wstrb_o));
         mem[wr_ptr + wr_cnt[7:0]] = m_axi_wdata_o;
         wr_cnt++;
         if (wr_cnt == `MEM_BURST_LEN) begin
            wr_busy = 1'b0;
            resp_pending = 1'b1;
         end
      end
      m_axi_wready_i <= wr_busy & (~stall_en | rng_model[3]);
      if (m_axi_bvalid_i && m_axi_bready_o)
         m_axi_bvalid_i <= 1'b0;
      else if (resp_pending && !m_axi_bvalid_i && (!stall_en || rng_model[4])) begin
         m_axi_bvalid_i <= 1'b1;
         resp_pending = 1'b0;
      end
   end

   // Cache side, collects refill words and feeds writeback words
   always @(posedge clk) begin
      if (read_next_o) begin
         rd_words[rd_got[3:0]] <= read_data_o;
         rd_got <= rd_got + 1;
      end
      if (write_next_o && wb_idx < `MEM_BURST_LEN - 1) begin
         wb_idx <= wb_idx + 1;
         write_data_i <= wb_words[wb_idx + 1];
      end
      if (write_done_o)
         done_cnt <= done_cnt + 1;
   end

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (exp !== act) begin
         $display("Mismatch %s: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_ctrl(input string name, input ctrl_word_u exp, input ctrl_word_u act);
      if (exp !== act) begin
         $display("Mismatch %s: expected %h, actual %h", name, exp.raw, act.raw);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("Mismatch %s: expected %b, actual %b", name, exp, act);
         errors++;
      end
   endtask

   task automatic test_done(input string name, input int errors_before);
      $display("%s: %s", name, (errors == errors_before) ? "ok" : "errors found");
   endtask

   task automatic reg_write(input reg_addr_t a, input word_t d, input strb_t s);
      @(posedge clk);
      s_axi_awaddr_i  <= a;
      s_axi_wdata_i   <= d;
      s_axi_wstrb_i   <= s;
      s_axi_awvalid_i <= 1'b1;
      s_axi_wvalid_i  <= 1'b1;
      do @(posedge clk); while (!s_axi_awready_o);
      check_bit("reg write wready with awready", 1'b1, s_axi_wready_o);
      s_axi_awvalid_i <= 1'b0;
      s_axi_wvalid_i  <= 1'b0;
      s_axi_bready_i  <= 1'b1;
      do @(posedge clk); while (!s_axi_bvalid_o);
      s_axi_bready_i  <= 1'b0;
   endtask

   task automatic reg_read(input reg_addr_t a, output word_t d);
      @(posedge clk);
      s_axi_araddr_i  <= a;
      s_axi_arvalid_i <= 1'b1;
      do @(posedge clk); while (!s_axi_arready_o);
      s_axi_arvalid_i <= 1'b0;
      s_axi_rready_i  <= 1'b1;
      do @(posedge clk); while (!s_axi_rvalid_o);
      d = s_axi_rdata_o;
      s_axi_rready_i  <= 1'b0;
   endtask

   // Starts a refill, a writeback or both on the same edge
   task automatic launch(input logic do_rd, input logic do_wr, input addr_t ra, input addr_t wa);
      @(posedge clk);
      rd_got   <= 0;
      wb_idx   <= 0;
      done_cnt <= 0;
      read_init_i  <= do_rd;
      write_init_i <= do_wr;
      read_address_i  <= ra;
      write_address_i <= wa;
      write_data_i    <= wb_words[0];
      @(posedge clk);
      read_init_i  <= 1'b0;
      write_init_i <= 1'b0;
   endtask

   task automatic test_reset();
      int e;
      word_t d;
      e = errors;
      check_bit("reset ce_o", 1'b0, ce_o);
      check_bit("reset interrupt_o", 1'b0, interrupt_o);
      check_bit("reset arvalid", 1'b0, m_axi_arvalid_o);
      check_bit("reset awvalid", 1'b0, m_axi_awvalid_o);
      check_bit("reset wvalid", 1'b0, m_axi_wvalid_o);
      check_bit("reset s_axi_bvalid", 1'b0, s_axi_bvalid_o);
      check_bit("reset s_axi_rvalid", 1'b0, s_axi_rvalid_o);
      reg_read(`MEM_REG_CTRL, d);
      check_word("reset ctrl", '0, d);
      reg_read(`MEM_REG_BASE, d);
      check_word("reset base", '0, d);
      reg_read(`MEM_REG_PC, d);
      check_word("reset pc", pc_i, d);
      reg_read(`MEM_REG_STATUS, d);
      check_word("reset status", '0, d);
      reg_read(4'd2, d);
      check_word("unmapped read", '0, d);
      test_done("test_reset", e);
   endtask

   task automatic test_regs();
      int e;
      word_t d;
      ctrl_word_u exp;
      e = errors;
      reg_write(`MEM_REG_CTRL, 32'hFFFF_FF01, 4'b0001);
      exp.raw = 32'h0000_0001;
      reg_read(`MEM_REG_CTRL, d);
      check_ctrl("ctrl low byte", exp, d);
      check_bit("ce_o set", 1'b1, ce_o);
      reg_write(`MEM_REG_CTRL, 32'h1234_5600, 4'b1110);
      exp.raw = 32'h1234_5601;
      reg_read(`MEM_REG_CTRL, d);
      check_ctrl("ctrl upper bytes", exp, d);
      reg_write(`MEM_REG_CTRL, 32'h0, 4'b1111);
      check_bit("ce_o cleared", 1'b0, ce_o);
      reg_write(`MEM_REG_BASE, 32'h0000_0400, 4'b1111);
      reg_write(`MEM_REG_BASE, 32'hFFFF_FF80, 4'b0001);
      reg_read(`MEM_REG_BASE, d);
      check_word("base merge", 32'h0000_0480, d);
      reg_write(`MEM_REG_PC, 32'h0000_DEAD, 4'b1111);
      reg_read(`MEM_REG_PC, d);
      check_word("pc write ignored", pc_i, d);
      test_done("test_regs", e);
   endtask

   task automatic test_irq();
      int e;
      word_t d;
      e = errors;
      @(posedge clk);
      fin_interrupt_i <= 1'b1;
      @(posedge clk);
      fin_interrupt_i <= 1'b0;
      reg_read(`MEM_REG_STATUS, d);
      check_word("status set", 32'h1, d);
      check_bit("irq masked", 1'b0, interrupt_o);
      reg_write(`MEM_REG_CTRL, 32'h2, 4'b1111);
      repeat (2) @(posedge clk);
      check_bit("irq enabled", 1'b1, interrupt_o);
      reg_write(`MEM_REG_STATUS, 32'h1, 4'b1111);
      repeat (2) @(posedge clk);
      reg_read(`MEM_REG_STATUS, d);
      check_word("status cleared", '0, d);
      check_bit("irq cleared", 1'b0, interrupt_o);
      reg_write(`MEM_REG_CTRL, 32'h0, 4'b1111);
      test_done("test_irq", e);
   endtask

   task automatic run_bursts(input string name, input logic do_rd, input logic do_wr,
                             input addr_t ra, input addr_t wa);
      int e;
      addr_t base;
      e = errors;
      cur_test = name;
      base = 32'h0000_0100;
      reg_write(`MEM_REG_BASE, base, 4'b1111);
      for (int k = 0; k < 16; k++) begin
         rng_data = xorshift(rng_data);
         wb_words[k] = rng_data;
      end
      launch(do_rd, do_wr, ra, wa);
      while ((do_rd && rd_got < 16) || (do_wr && done_cnt == 0))
         @(posedge clk);
      repeat (4) @(posedge clk);
      if (do_rd) begin
         check_word({name, " araddr"}, base + ra, ar_seen);
         check_word({name, " next pulses"}, 32'd16, word_t'(rd_got));
         for (int k = 0; k < 16; k++)
            check_word({name, " refill word"}, fill_word(8'((base + ra) >> 2) + 8'(k)),
                       rd_words[k]);
      end
      if (do_wr) begin
         check_word({name, " awaddr"}, base + wa, aw_seen);
         check_word({name, " done pulses"}, 32'd1, word_t'(done_cnt));
         for (int k = 0; k < 16; k++)
            check_word({name, " stored word"}, wb_words[k], mem[8'((base + wa) >> 2) + 8'(k)]);
      end
      test_done(name, e);
   endtask

   initial begin
      rst_n_i = 1'b0;
      {s_axi_awaddr_i, s_axi_araddr_i, s_axi_wdata_i, s_axi_wstrb_i} = '0;
      {s_axi_awvalid_i, s_axi_wvalid_i, s_axi_bready_i, s_axi_arvalid_i, s_axi_rready_i} = '0;
      pc_i = 32'h0000_1234;
      fin_interrupt_i = 1'b0;
      {read_init_i, write_init_i, read_address_i, write_address_i, write_data_i} = '0;
      {m_axi_awready_i, m_axi_wready_i, m_axi_bvalid_i, m_axi_arready_i} = '0;
      {m_axi_rdata_i, m_axi_rlast_i, m_axi_rvalid_i} = '0;
      {rd_got, wb_idx, done_cnt, errors, cycles, rd_cnt, wr_cnt} = '0;
      {rd_busy, wr_busy, resp_pending, stall_en, rd_ptr, wr_ptr} = '0;
      {ar_seen, aw_seen} = '0;
      rng_model = 32'd46;
      rng_data  = 32'd46;
      for (int i = 0; i < 256; i++)
         mem[i] = fill_word(8'(i));
      repeat (5) @(posedge clk);
      rst_n_i <= 1'b1;
      @(posedge clk);
      test_reset();
      test_regs();
      test_irq();
      run_bursts("test_refill", 1'b1, 1'b0, 32'h40, 32'h0);
      run_bursts("test_writeback", 1'b0, 1'b1, 32'h0, 32'h80);
      stall_en = 1'b1;
      run_bursts("test_stalled_pair", 1'b1, 1'b1, 32'h0, 32'hC0);
      $display("Checks done: %0d errors in %0d cycles", errors, cycles);
      if (errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

//--- dv/mem_subsystem_properties.sv
`timescale 1ns/1ps

module mem_subsystem_properties (
   input logic clk,
   input logic rst_n_i,
   input logic m_axi_arvalid_o,
   input logic m_axi_arready_i,
   input logic m_axi_awvalid_o,
   input logic m_axi_awready_i,
   input logic m_axi_wvalid_o,
   input logic m_axi_wlast_o,
   input logic s_axi_bvalid_o,
   input logic s_axi_bready_i
);

   // Address valids stay up until the slave takes them
   ar_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
      m_axi_arvalid_o && !m_axi_arready_i |=> m_axi_arvalid_o)
      else $error("arvalid dropped before arready");

   aw_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
      m_axi_awvalid_o && !m_axi_awready_i |=> m_axi_awvalid_o)
      else $error("awvalid dropped before awready");

   wlast_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
      m_axi_wlast_o |-> m_axi_wvalid_o)
      else $error("wlast high without wvalid");

   b_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
      s_axi_bvalid_o && !s_axi_bready_i |=> s_axi_bvalid_o)
      else $error("AXI-lite bvalid dropped before bready");

endmodule

bind mem_subsystem_top mem_subsystem_properties props0 (
   .clk             (clk),
   .rst_n_i         (rst_n_i),
   .m_axi_arvalid_o (m_axi_arvalid_o),
   .m_axi_arready_i (m_axi_arready_i),
   .m_axi_awvalid_o (m_axi_awvalid_o),
   .m_axi_awready_i (m_axi_awready_i),
   .m_axi_wvalid_o  (m_axi_wvalid_o),
   .m_axi_wlast_o   (m_axi_wlast_o),
   .s_axi_bvalid_o  (s_axi_bvalid_o),
   .s_axi_bready_i  (s_axi_bready_i)
);

//--- source/mem_subsystem_top.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_subsystem_top import mem_pkg::*; (
   input  logic      clk,
   input  logic      rst_n_i,
   // AXI-lite control slave
   input  reg_addr_t s_axi_awaddr_i,
   input  logic      s_axi_awvalid_i,
   output logic      s_axi_awready_o,
   input  word_t     s_axi_wdata_i,
   input  strb_t     s_axi_wstrb_i,
   input  logic      s_axi_wvalid_i,
   output logic      s_axi_wready_o,
   output logic      s_axi_bvalid_o,
   input  logic      s_axi_bready_i,
   input  reg_addr_t s_axi_araddr_i,
   input  logic      s_axi_arvalid_i,
   output logic      s_axi_arready_o,
   output word_t     s_axi_rdata_o,
   output logic      s_axi_rvalid_o,
   input  logic      s_axi_rready_i,
   // Core
   output logic      ce_o,
   input  addr_t     pc_i,
   input  logic      fin_interrupt_i,
   output logic      interrupt_o,
   // Scalar cache
   input  logic      read_init_i,
   input  addr_t     read_address_i,
   output word_t     read_data_o,
   output logic      read_next_o,
   input  logic      write_init_i,
   input  addr_t     write_address_i,
   input  word_t     write_data_i,
   output logic      write_next_o,
   output logic      write_done_o,
   // AXI burst master to DDR
   output addr_t     m_axi_awaddr_o,
   output logic      m_axi_awvalid_o,
   input  logic      m_axi_awready_i,
   output word_t     m_axi_wdata_o,
   output strb_t     m_axi_wstrb_o,
   output logic      m_axi_wlast_o,
   output logic      m_axi_wvalid_o,
   input  logic      m_axi_wready_i,
   input  logic      m_axi_bvalid_i,
   output logic      m_axi_bready_o,
   output addr_t     m_axi_araddr_o,
   output logic      m_axi_arvalid_o,
   input  logic      m_axi_arready_i,
   input  word_t     m_axi_rdata_i,
   input  logic      m_axi_rlast_i,
   input  logic      m_axi_rvalid_i,
   output logic      m_axi_rready_o
);

   addr_t base_address;   // DDR offset of the program

   reg_access_if #(
      .addr_type (reg_addr_t),
      .data_type (word_t),
      .strb_type (strb_t)
   ) reg_bus ();

   axil_slave axil_slave_inst (
      .clk             (clk),
      .rst_n_i         (rst_n_i),
      .s_axi_awaddr_i  (s_axi_awaddr_i),
      .s_axi_awvalid_i (s_axi_awvalid_i),
      .s_axi_awready_o (s_axi_awready_o),
      .s_axi_wdata_i   (s_axi_wdata_i),
      .s_axi_wstrb_i   (s_axi_wstrb_i),
      .s_axi_wvalid_i  (s_axi_wvalid_i),
      .s_axi_wready_o  (s_axi_wready_o),
      .s_axi_bvalid_o  (s_axi_bvalid_o),
      .s_axi_bready_i  (s_axi_bready_i),
      .s_axi_araddr_i  (s_axi_araddr_i),
      .s_axi_arvalid_i (s_axi_arvalid_i),
      .s_axi_arready_o (s_axi_arready_o),
      .s_axi_rdata_o   (s_axi_rdata_o),
      .s_axi_rvalid_o  (s_axi_rvalid_o),
      .s_axi_rready_i  (s_axi_rready_i),
      .regs            (reg_bus.slave_mp)
   );

   ctrl_regs ctrl_regs_inst (
      .clk             (clk),
      .rst_n_i         (rst_n_i),
      .regs            (reg_bus.regs_mp),
      .pc_i            (pc_i),
      .fin_interrupt_i (fin_interrupt_i),
      .ce_o            (ce_o),
      .base_address_o  (base_address),
      .interrupt_o     (interrupt_o)
   );

   // Refill path
   burst_read_master burst_read_master_inst (
      .clk             (clk),
      .rst_n_i         (rst_n_i),
      .base_address_i  (base_address),
      .read_init_i     (read_init_i),
      .read_address_i  (read_address_i),
      .read_data_o     (read_data_o),
      .read_next_o     (read_next_o),
      .m_axi_araddr_o  (m_axi_araddr_o),
      .m_axi_arvalid_o (m_axi_arvalid_o),
      .m_axi_arready_i (m_axi_arready_i),
      .m_axi_rdata_i   (m_axi_rdata_i),
      .m_axi_rlast_i   (m_axi_rlast_i),
      .m_axi_rvalid_i  (m_axi_rvalid_i),
      .m_axi_rready_o  (m_axi_rready_o)
   );

   // Writeback path
   burst_write_master burst_write_master_inst (
      .clk             (clk),
      .rst_n_i         (rst_n_i),
      .base_address_i  (base_address),
      .write_init_i    (write_init_i),
      .write_address_i (write_address_i),
      .write_data_i    (write_data_i),
      .write_next_o    (write_next_o),
      .write_done_o    (write_done_o),
      .m_axi_awaddr_o  (m_axi_awaddr_o),
      .m_axi_awvalid_o (m_axi_awvalid_o),
      .m_axi_awready_i (m_axi_awready_i),
      .m_axi_wdata_o   (m_axi_wdata_o),
      .m_axi_wstrb_o   (m_axi_wstrb_o),
      .m_axi_wlast_o   (m_axi_wlast_o),
      .m_axi_wvalid_o  (m_axi_wvalid_o),
      .m_axi_wready_i  (m_axi_wready_i),
      .m_axi_bvalid_i  (m_axi_bvalid_i),
      .m_axi_bready_o  (m_axi_bready_o)
   );

endmodule

//--- source/burst_write_master.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module burst_write_master import mem_pkg::*; (
   input  logic  clk,
   input  logic  rst_n_i,
   input  addr_t base_address_i,
   input  logic  write_init_i,
   input  addr_t write_address_i,
   input  word_t write_data_i,
   output logic  write_next_o,
   output logic  write_done_o,
   output addr_t m_axi_awaddr_o,
   output logic  m_axi_awvalid_o,
   input  logic  m_axi_awready_i,
   output word_t m_axi_wdata_o,
   output strb_t m_axi_wstrb_o,
   output logic  m_axi_wlast_o,
   output logic  m_axi_wvalid_o,
   input  logic  m_axi_wready_i,
   input  logic  m_axi_bvalid_i,
   output logic  m_axi_bready_o
);

   typedef enum logic [1:0] {
      st_idle,
      st_addr,
      st_data,
      st_resp
   } state_t;

   state_t                            state_q;
   addr_t                             awaddr_q;
   logic [$clog2(`MEM_BURST_LEN)-1:0] beat_q;
   logic                              done_q;
   logic                              wvalid;
   logic                              last_beat;
   logic                              beat;

   assign wvalid    = (state_q == st_data);
   assign beat      = wvalid & m_axi_wready_i;
   // Burst length is a power of two, so the last beat is all ones
   assign last_beat = &beat_q;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= st_idle;
         beat_q  <= '0;
         done_q  <= 1'b0;
      end else begin
         done_q <= (state_q == st_resp) & m_axi_bvalid_i;
         case (state_q)
            st_idle: if (write_init_i) state_q <= st_addr;
            st_addr: begin
               beat_q <= '0;
               if (m_axi_awready_i)
                  state_q <= st_data;
            end
            st_data: begin
               if (beat) begin
                  beat_q <= beat_q + 1'b1;
                  if (last_beat)
                     state_q <= st_resp;
               end
            end
            st_resp: if (m_axi_bvalid_i) state_q <= st_idle;
            default: state_q <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (write_init_i && state_q == st_idle)
         awaddr_q <= base_address_i + write_address_i;
   end

   assign m_axi_awaddr_o  = awaddr_q;
   assign m_axi_awvalid_o = (state_q == st_addr);
   assign m_axi_wvalid_o  = wvalid;
   assign m_axi_wdata_o   = write_data_i;   // Cache holds the word until write_next_o
   assign m_axi_wstrb_o   = '1;
   assign m_axi_wlast_o   = last_beat;      // Counter wraps to zero on the last beat
   assign m_axi_bready_o  = (state_q == st_resp);
   assign write_next_o    = beat;
   assign write_done_o    = done_q;

endmodule

//--- source/burst_read_master.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module burst_read_master import mem_pkg::*; (
   input  logic  clk,
   input  logic  rst_n_i,
   input  addr_t base_address_i,
   input  logic  read_init_i,
   input  addr_t read_address_i,
   output word_t read_data_o,
   output logic  read_next_o,
   output addr_t m_axi_araddr_o,
   output logic  m_axi_arvalid_o,
   input  logic  m_axi_arready_i,
   input  word_t m_axi_rdata_i,
   input  logic  m_axi_rlast_i,
   input  logic  m_axi_rvalid_i,
   output logic  m_axi_rready_o
);

   typedef enum logic [1:0] {
      st_idle,
      st_addr,
      st_data
   } state_t;

   state_t state_q;
   addr_t  araddr_q;
   word_t  data_q;
   logic   next_q;
   logic   beat;

   assign beat = (state_q == st_data) & m_axi_rvalid_i;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= st_idle;
         next_q  <= 1'b0;
      end else begin
         next_q <= beat;
         case (state_q)
            st_idle: if (read_init_i) state_q <= st_addr;
            st_addr: if (m_axi_arready_i) state_q <= st_data;
            st_data: if (beat && m_axi_rlast_i) state_q <= st_idle;
            default: state_q <= st_idle;
         endcase
      end
   end

   // Address and beat payload
   always_ff @(posedge clk) begin
      if (read_init_i && state_q == st_idle)
         araddr_q <= base_address_i + read_address_i;
      if (beat)
         data_q <= m_axi_rdata_i;
   end

   assign m_axi_araddr_o  = araddr_q;
   assign m_axi_arvalid_o = (state_q == st_addr);
   assign m_axi_rready_o  = (state_q == st_data);   // Cache never stalls
   assign read_data_o     = data_q;
   assign read_next_o     = next_q;

endmodule

//--- source/ctrl_regs.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module ctrl_regs import mem_pkg::*; (
   input  logic  clk,
   input  logic  rst_n_i,
   reg_access_if.regs_mp regs,
   input  addr_t pc_i,
   input  logic  fin_interrupt_i,
   output logic  ce_o,
   output addr_t base_address_o,
   output logic  interrupt_o
);

   ctrl_word_u ctrl_q;
   addr_t      base_q;
   logic       fin_q;       // Sticky, set by the core
   logic       irq_q;
   logic       fin_clr;

   function automatic word_t strb_merge(word_t old_w, word_t new_w, strb_t strb);
      word_t merged;
      merged = old_w;
      for (int i = 0; i < `MEM_DATA_W / 8; i++) begin
         if (strb[i])
            merged[8*i +: 8] = new_w[8*i +: 8];
      end
      return merged;
   endfunction

   // Write one to bit 0 of status
   assign fin_clr = regs.wr_en & (regs.wr_addr == `MEM_REG_STATUS) &
                    regs.wr_strb[0] & regs.wr_data[0];

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ctrl_q <= '0;
         base_q <= '0;
         fin_q  <= 1'b0;
         irq_q  <= 1'b0;
      end else begin
         if (regs.wr_en && regs.wr_addr == `MEM_REG_CTRL)
            ctrl_q.raw <= strb_merge(ctrl_q.raw, regs.wr_data, regs.wr_strb);
         if (regs.wr_en && regs.wr_addr == `MEM_REG_BASE)
            base_q <= strb_merge(base_q, regs.wr_data, regs.wr_strb);
         if (fin_interrupt_i)
            fin_q <= 1'b1;   // Set beats clear
         else if (fin_clr)
            fin_q <= 1'b0;
         irq_q <= fin_q & ctrl_q.fields.irq_en;
      end
   end

   always_comb begin
      case (regs.rd_addr)
         `MEM_REG_CTRL:   regs.rd_data = ctrl_q.raw;
         `MEM_REG_BASE:   regs.rd_data = base_q;
         `MEM_REG_PC:     regs.rd_data = pc_i;   // Live value
         `MEM_REG_STATUS: regs.rd_data = {{(`MEM_DATA_W-1){1'b0}}, fin_q};
         default:         regs.rd_data = '0;
      endcase
   end

   assign ce_o           = ctrl_q.fields.ce;
   assign base_address_o = base_q;
   assign interrupt_o    = irq_q;

endmodule

//--- source/axil_slave.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module axil_slave import mem_pkg::*; (
   input  logic      clk,
   input  logic      rst_n_i,
   input  reg_addr_t s_axi_awaddr_i,
   input  logic      s_axi_awvalid_i,
   output logic      s_axi_awready_o,
   input  word_t     s_axi_wdata_i,
   input  strb_t     s_axi_wstrb_i,
   input  logic      s_axi_wvalid_i,
   output logic      s_axi_wready_o,
   output logic      s_axi_bvalid_o,
   input  logic      s_axi_bready_i,
   input  reg_addr_t s_axi_araddr_i,
   input  logic      s_axi_arvalid_i,
   output logic      s_axi_arready_o,
   output word_t     s_axi_rdata_o,
   output logic      s_axi_rvalid_o,
   input  logic      s_axi_rready_i,
   reg_access_if.slave_mp regs
);

   logic  aw_ready_q;   // Shared by AW and W
   logic  b_valid_q;
   logic  ar_ready_q;
   logic  r_valid_q;
   word_t r_data_q;
   logic  wr_accept;
   logic  rd_accept;

   assign wr_accept = aw_ready_q & s_axi_awvalid_i & s_axi_wvalid_i;
   assign rd_accept = ar_ready_q & s_axi_arvalid_i;

   // Write channel, AW and W taken together
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         aw_ready_q <= 1'b0;
         b_valid_q  <= 1'b0;
      end else begin
         aw_ready_q <= ~aw_ready_q & ~b_valid_q & s_axi_awvalid_i & s_axi_wvalid_i;
         if (wr_accept)
            b_valid_q <= 1'b1;
         else if (s_axi_bready_i)
            b_valid_q <= 1'b0;
      end
   end

   // Read channel
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ar_ready_q <= 1'b0;
         r_valid_q  <= 1'b0;
      end else begin
         ar_ready_q <= ~ar_ready_q & ~r_valid_q & s_axi_arvalid_i;
         if (rd_accept)
            r_valid_q <= 1'b1;
         else if (s_axi_rready_i)
            r_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_accept)
         r_data_q <= regs.rd_data;   // Held until rready
   end

   assign s_axi_awready_o = aw_ready_q;
   assign s_axi_wready_o  = aw_ready_q;
   assign s_axi_bvalid_o  = b_valid_q;
   assign s_axi_arready_o = ar_ready_q;
   assign s_axi_rvalid_o  = r_valid_q;
   assign s_axi_rdata_o   = r_data_q;

   assign regs.wr_en   = wr_accept;
   assign regs.wr_addr = s_axi_awaddr_i;
   assign regs.wr_data = s_axi_wdata_i;
   assign regs.wr_strb = s_axi_wstrb_i;
   assign regs.rd_addr = s_axi_araddr_i;

endmodule

//--- source/reg_access_if.sv
`timescale 1ns/1ps

interface reg_access_if #(
   parameter type addr_type = logic,
   parameter type data_type = logic,
   parameter type strb_type = logic
);

   logic     wr_en;     // One cycle per accepted write
   addr_type wr_addr;
   data_type wr_data;
   strb_type wr_strb;
   addr_type rd_addr;
   data_type rd_data;   // Combinational from rd_addr

   modport slave_mp (
      output wr_en, wr_addr, wr_data, wr_strb, rd_addr,
      input  rd_data
   );

   modport regs_mp (
      input  wr_en, wr_addr, wr_data, wr_strb, rd_addr,
      output rd_data
   );

endinterface

//--- source/mem_pkg.sv
`include "mem_settings.svh"

package mem_pkg;

   typedef logic [`MEM_DATA_W-1:0]     word_t;
   typedef logic [`MEM_ADDR_W-1:0]     addr_t;
   typedef logic [`MEM_REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [`MEM_DATA_W/8-1:0]   strb_t;

   // Control register layout
   typedef struct packed {
      logic [`MEM_DATA_W-3:0] reserved;
      logic                   irq_en;   // Unmasks interrupt_o
      logic                   ce;       // Core clock enable
   } ctrl_fields_t;

   // Written as a raw word, decoded as fields
   typedef union packed {
      word_t        raw;
      ctrl_fields_t fields;
   } ctrl_word_u;

endpackage

//--- source/mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Bus widths
`define MEM_DATA_W      32
`define MEM_ADDR_W      32
`define MEM_REG_ADDR_W  4

// Cache block and the AXI burst that moves it
`define MEM_BLOCK_BYTES 64
`define MEM_BURST_LEN   (`MEM_BLOCK_BYTES / (`MEM_DATA_W / 8))

// AXI-lite register map, byte offsets
`define MEM_REG_CTRL    4'd0
`define MEM_REG_BASE    4'd4
`define MEM_REG_PC      4'd8
`define MEM_REG_STATUS  4'd12

`endif
